// File: src/fpu_rnd_pkg.sv
`default_nettype none

package fpu_rnd_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int FRACT_W = 28;  // add/mul fraction incl. appended r,s
  localparam int ALIGN_W = 35;  // working fraction in align stage
  localparam int EXP_W   = 10;  // extended exponent, room for over/underflow
  localparam int SHIFT_W = 5;

  localparam int EXP_MAX = 254; // largest finite biased exponent

  // 31-bit magnitudes, sign goes on top
  localparam logic [30:0] INF_BITS  = 31'h7f80_0000;
  localparam logic [30:0] QNAN_BITS = 31'h7fc0_0000;
  localparam logic [30:0] SNAN_BITS = 31'h7fbf_ffff;

  localparam logic [31:0] INT_MAX = 32'h7fff_ffff; // f2i saturation

  typedef enum logic [1:0] {
    RM_NEAREST = 2'b00,
    RM_TO_ZERO = 2'b01,
    RM_TO_INFP = 2'b10,
    RM_TO_INFM = 2'b11
  } rmode_e;

  // special-input flags from a producer
  typedef struct packed {
    logic inv;      // invalid operation
    logic inf;      // infinity input
    logic snan;     // signalling nan input
    logic qnan;     // quiet nan input
    logic nan_sign; // sign for the output nan
  } nan_flags_t;

  ////////////////////
  // producer payloads
  ////////////////////

  typedef struct packed {
    logic                 sign;
    logic                 sub_zero; // exact zero from subtraction
    logic [SHIFT_W-1:0]   shl;
    logic [EXP_W-1:0]     exp_shl;
    logic [EXP_W-1:0]     exp_sh0;
    logic [FRACT_W-1:0]   fract;
    nan_flags_t           flags;
  } add_src_t;

  typedef struct packed {
    logic                 sign;
    logic [SHIFT_W-1:0]   shr;
    logic                 shl;      // mul needs at most one left step
    logic [EXP_W-1:0]     exp_shr;
    logic [EXP_W-1:0]     exp_shl;
    logic [EXP_W-1:0]     exp_sh0;
    logic [FRACT_W-1:0]   fract;
    nan_flags_t           flags;
  } mul_src_t;

  typedef struct packed {
    logic                 sign;
    logic [23:0]          int24;    // unsigned magnitude before shift
    logic [SHIFT_W-1:0]   shr;
    logic [3:0]           shl;
    logic                 ovf;      // magnitude does not fit int32
    logic                 snan;
  } f2i_src_t;

  ////////////////////
  // pipe structs
  ////////////////////

  typedef struct packed {
    logic                 valid;
    logic                 sign;
    logic [ALIGN_W-1:0]   fract;
    logic [SHIFT_W-1:0]   shr;
    logic [SHIFT_W-1:0]   shl;
    logic [EXP_W-1:0]     exp_shr;
    logic [EXP_W-1:0]     exp_shl;
    logic [EXP_W-1:0]     exp_sh0;
    logic                 carry;    // add/mul overflow bit
    nan_flags_t           flags;
    logic                 is_f2i;
    logic                 f2i_ovf;
  } align_req_t;

  typedef struct packed {
    logic                 sign;
    logic [EXP_W-1:0]     exp;
    logic [31:0]          fract32;
    logic [1:0]           rs;       // round, sticky
    nan_flags_t           flags;
    logic                 is_f2i;
    logic                 f2i_ovf;
  } stage1_t;

  typedef struct packed {
    logic ovf;
    logic unf;
    logic snf;
    logic qnf;
    logic zf;
    logic ixf;
    logic ivf;
    logic inf;
  } fpcsr_t;

endpackage

`default_nettype wire

// File: src/fpu_src_mux.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_src_mux (
  input  logic                    add_rdy_i,
  input  logic                    mul_rdy_i,
  input  logic                    f2i_rdy_i,
  input  fpu_rnd_pkg::add_src_t   add_i,
  input  fpu_rnd_pkg::mul_src_t   mul_i,
  input  fpu_rnd_pkg::f2i_src_t   f2i_i,
  input  fpu_rnd_pkg::rmode_e     rmode_i,
  output fpu_rnd_pkg::align_req_t req_o
);

  localparam int AW   = fpu_rnd_pkg::ALIGN_W;
  localparam int PADW = fpu_rnd_pkg::ALIGN_W - fpu_rnd_pkg::FRACT_W; // zero pad of add/mul
  localparam int SW   = fpu_rnd_pkg::SHIFT_W;
  localparam int EW   = fpu_rnd_pkg::EXP_W;

  logic                   add_sign;  // sign after exact-zero fixup
  fpu_rnd_pkg::nan_flags_t f2i_flags;

  // x - x gives +0 but -0 when rounding toward -inf
  assign add_sign = add_i.sub_zero ? (rmode_i == fpu_rnd_pkg::RM_TO_INFM) : add_i.sign;

  // f2i reports only snan and uses the operand sign as nan sign
  always_comb begin
    f2i_flags          = '0;
    f2i_flags.snan     = f2i_i.snan;
    f2i_flags.nan_sign = f2i_i.sign;
  end

  ////////////////////
  // and-or merge
  ////////////////////

  always_comb begin
    req_o.valid = add_rdy_i | mul_rdy_i | f2i_rdy_i;

    req_o.sign  = (add_rdy_i & add_sign) |
                  (mul_rdy_i & mul_i.sign) |
                  (f2i_rdy_i & f2i_i.sign);

    // f2i magnitude sits at 26:3 so bits 2:0 act as guard/round/sticky
    req_o.fract = ({AW{add_rdy_i}} & {{PADW{1'b0}}, add_i.fract}) |
                  ({AW{mul_rdy_i}} & {{PADW{1'b0}}, mul_i.fract}) |
                  ({AW{f2i_rdy_i}} & {8'd0, f2i_i.int24, 3'd0});

    // only the carry shifts an add result right
    req_o.shr   = ({SW{mul_rdy_i}} & mul_i.shr) |
                  ({SW{f2i_rdy_i}} & f2i_i.shr);

    req_o.shl   = ({SW{add_rdy_i}} & add_i.shl) |
                  ({SW{mul_rdy_i}} & {{(SW-1){1'b0}}, mul_i.shl}) |
                  ({SW{f2i_rdy_i}} & {1'b0, f2i_i.shl});

    // f2i has no exponent so all three stay zero
    req_o.exp_shr = {EW{mul_rdy_i}} & mul_i.exp_shr; // only mul shifts right
    req_o.exp_shl = ({EW{add_rdy_i}} & add_i.exp_shl) |
                    ({EW{mul_rdy_i}} & mul_i.exp_shl);
    req_o.exp_sh0 = ({EW{add_rdy_i}} & add_i.exp_sh0) |
                    ({EW{mul_rdy_i}} & mul_i.exp_sh0);

    // msb of add/mul fraction means 1x.xxx and one step right
    req_o.carry = (add_rdy_i & add_i.fract[fpu_rnd_pkg::FRACT_W-1]) |
                  (mul_rdy_i & mul_i.fract[fpu_rnd_pkg::FRACT_W-1]);

    req_o.flags = ({5{add_rdy_i}} & add_i.flags) |
                  ({5{mul_rdy_i}} & mul_i.flags) |
                  ({5{f2i_rdy_i}} & f2i_flags);

    req_o.is_f2i  = f2i_rdy_i;
    req_o.f2i_ovf = f2i_rdy_i & f2i_i.ovf;
  end

endmodule

`default_nettype wire

// File: src/fpu_align.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_align (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    adv_i,    // pipe advance
  input  logic                    flush_i,
  input  fpu_rnd_pkg::align_req_t req_i,
  output fpu_rnd_pkg::stage1_t    s1_o,
  output logic                    s1_valid_o
);

  localparam int AW = fpu_rnd_pkg::ALIGN_W;
  localparam int SW = fpu_rnd_pkg::SHIFT_W;
  localparam int EW = fpu_rnd_pkg::EXP_W;

  logic [SW-1:0]  shr;         // effective right shift
  logic           shr_req;     // producer asked for a right shift
  logic           do_shr;
  logic [AW-1:0]  fract_sh;    // aligned fraction
  logic [SW:0]    sticky_pos;  // first bit kept above the sticky field
  logic [AW-1:0]  lo_mask;
  logic           sticky_r;
  logic           sticky_l;
  logic           sticky;
  logic [EW-1:0]  exp_sel;
  fpu_rnd_pkg::stage1_t s1_next;

  ////////////////////
  // shift select
  ////////////////////

  assign shr_req = |req_i.shr;
  // no explicit shift: carry alone moves one place right
  assign shr     = shr_req ? req_i.shr : {{(SW-1){1'b0}}, req_i.carry};
  assign do_shr  = |shr;

  assign fract_sh = do_shr ? (req_i.fract >> shr) : (req_i.fract << req_i.shl);

  // right shift: everything that ends up below bit 2 of the result
  assign sticky_pos = {1'b0, shr} + (SW+1)'(2);
  assign lo_mask    = (AW'(1) << sticky_pos) - AW'(1);
  assign sticky_r   = |(req_i.fract & lo_mask);

  // left shift: whatever is still sitting in bits 1:0
  assign sticky_l = |fract_sh[1:0];

  assign sticky = do_shr ? sticky_r : sticky_l;

  // exponent matching the chosen shift
  always_comb begin
    if (shr_req) begin
      exp_sel = req_i.exp_shr;
    end else if (req_i.shl == '0) begin
      exp_sel = req_i.exp_sh0 + EW'(req_i.carry); // +1 on carry step
    end else begin
      exp_sel = req_i.exp_shl;
    end
  end

  always_comb begin
    s1_next.sign    = req_i.sign;
    s1_next.exp     = exp_sel;
    s1_next.fract32 = fract_sh[AW-1:3];
    s1_next.rs      = {fract_sh[2], sticky}; // round bit, sticky
    s1_next.flags   = req_i.flags;
    s1_next.is_f2i  = req_i.is_f2i;
    s1_next.f2i_ovf = req_i.f2i_ovf;
  end

  ////////////////////
  // stage 1 register
  ////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_o <= s1_next; // payload only, valid below
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid_o <= 1'b0;
    end else if (flush_i) begin
      s1_valid_o <= 1'b0; // flush beats advance
    end else if (adv_i) begin
      s1_valid_o <= req_i.valid;
    end
  end

endmodule

`default_nettype wire

// File: src/fpu_round.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_round (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  adv_i,
  input  logic                  flush_i,
  input  fpu_rnd_pkg::rmode_e   rmode_i,   // not pipelined
  input  fpu_rnd_pkg::stage1_t  s1_i,
  input  logic                  s1_valid_i,
  output logic [31:0]           result_o,
  output logic                  valid_o,
  output fpu_rnd_pkg::fpcsr_t   fpcsr_o
);

  localparam int EW = fpu_rnd_pkg::EXP_W;

  logic         rm_nearest;
  logic         rm_to_infp;
  logic         rm_to_infm;
  logic         g;            // fraction lsb
  logic         r;
  logic         s;
  logic         lost;         // inexact
  logic         rnd_up;
  logic [31:0]  fract_rnd;
  logic         f32_shr;      // rounding carried into bit 24
  logic [EW-1:0] f32_exp;
  logic [23:0]  f32_fract;
  logic         f32_dn;       // no hidden one so denormal or zero
  logic         i32_inv;
  logic [31:0]  i32_int;
  logic         i32_zero;
  logic [31:0]  i32_res;
  logic [31:0]  res;
  logic         res_ixf;
  logic         res_ovf;
  logic         res_inf;
  logic         res_unf;
  logic         res_zf;
  fpu_rnd_pkg::fpcsr_t csr_next;

  assign rm_nearest = (rmode_i == fpu_rnd_pkg::RM_NEAREST);
  assign rm_to_infp = (rmode_i == fpu_rnd_pkg::RM_TO_INFP);
  assign rm_to_infm = (rmode_i == fpu_rnd_pkg::RM_TO_INFM);

  ////////////////////
  // round decision
  ////////////////////

  assign g    = s1_i.fract32[0];
  assign r    = s1_i.rs[1];
  assign s    = s1_i.rs[0];
  assign lost = r | s;

  // nearest rounds up above half or on an exact half with odd lsb
  assign rnd_up = (rm_nearest & r & s) |
                  (rm_nearest & g & r & ~s) |
                  (rm_to_infp & ~s1_i.sign & lost) |
                  (rm_to_infm &  s1_i.sign & lost);

  assign fract_rnd = s1_i.fract32 + 32'(rnd_up);

  // 1.111..1 + 1 gives 10.000..0 and needs renormalizing
  assign f32_shr   = fract_rnd[24];
  assign f32_exp   = s1_i.exp + EW'(f32_shr);
  assign f32_fract = f32_shr ? fract_rnd[24:1] : fract_rnd[23:0];
  assign f32_dn    = ~f32_fract[23];

  ////////////////////
  // truncating f2i
  ////////////////////

  // positive magnitude reaching bit 31 does not fit
  assign i32_inv  = (~s1_i.sign & s1_i.fract32[31]) | s1_i.f2i_ovf;
  assign i32_int  = (s1_i.fract32 ^ {32{s1_i.sign}}) + 32'(s1_i.sign); // two's complement
  assign i32_zero = ~i32_inv & ~(|i32_int);
  // 7fffffff or 80000000
  assign i32_res  = i32_inv ? (fpu_rnd_pkg::INT_MAX ^ {32{s1_i.sign}}) : i32_int;

  ////////////////////
  // result select
  ////////////////////

  always_comb begin
    res     = '0;
    res_ixf = 1'b0;
    res_ovf = 1'b0;
    res_inf = 1'b0;
    res_unf = 1'b0;
    res_zf  = 1'b0;
    if (s1_i.is_f2i) begin
      res     = i32_res;
      res_ixf = lost;
      res_zf  = i32_zero;
    end else if (s1_i.flags.snan | s1_i.flags.qnan) begin
      res = {s1_i.flags.nan_sign, fpu_rnd_pkg::QNAN_BITS};
    end else if (s1_i.flags.inv) begin
      res = {s1_i.sign, fpu_rnd_pkg::SNAN_BITS};
    end else if ((f32_exp > EW'(fpu_rnd_pkg::EXP_MAX)) | s1_i.flags.inf) begin
      res     = {s1_i.sign, fpu_rnd_pkg::INF_BITS};
      res_ixf = lost | ~s1_i.flags.inf;  // overflow is always inexact
      res_ovf = ~s1_i.flags.inf;         // inf operand is not an overflow
      res_inf = 1'b1;
    end else if (f32_dn) begin
      res     = {s1_i.sign, 8'd0, f32_fract[22:0]};
      res_ixf = lost;
      res_unf = lost;
      res_zf  = ~(|f32_fract);
    end else begin
      res     = {s1_i.sign, f32_exp[7:0], f32_fract[22:0]};
      res_ixf = lost;
    end
  end

  always_comb begin
    csr_next.ovf = res_ovf;
    csr_next.unf = res_unf;
    csr_next.snf = s1_i.flags.inv | (s1_i.flags.snan & s1_i.is_f2i);
    csr_next.qnf = s1_i.flags.qnan;
    csr_next.zf  = res_zf;
    csr_next.ixf = res_ixf;
    csr_next.ivf = s1_i.flags.inv | (i32_inv & s1_i.is_f2i) | s1_i.flags.snan;
    csr_next.inf = res_inf;
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      result_o <= '0;
      valid_o  <= 1'b0;
      fpcsr_o  <= '0;
    end else if (flush_i) begin
      result_o <= '0; // drop whatever was in flight
      valid_o  <= 1'b0;
      fpcsr_o  <= '0;
    end else if (adv_i) begin
      valid_o <= s1_valid_i;
      if (s1_valid_i) begin
        result_o <= res; // bubbles keep the last result
        fpcsr_o  <= csr_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/fpu_rnd_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_rnd_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  adv_i,
  input  logic                  flush_i,
  input  fpu_rnd_pkg::rmode_e   rmode_i,
  // producers, one-hot readies
  input  logic                  add_rdy_i,
  input  fpu_rnd_pkg::add_src_t add_i,
  input  logic                  mul_rdy_i,
  input  fpu_rnd_pkg::mul_src_t mul_i,
  input  logic                  f2i_rdy_i,
  input  fpu_rnd_pkg::f2i_src_t f2i_i,
  // result
  output logic [31:0]           result_o,
  output logic                  valid_o,
  output fpu_rnd_pkg::fpcsr_t   fpcsr_o
);

  fpu_rnd_pkg::align_req_t req;      // merged request, combinational
  fpu_rnd_pkg::stage1_t    s1;       // align stage register
  logic                    s1_valid;

  fpu_src_mux i_fpu_src_mux (
    .add_rdy_i (add_rdy_i),
    .mul_rdy_i (mul_rdy_i),
    .f2i_rdy_i (f2i_rdy_i),
    .add_i     (add_i),
    .mul_i     (mul_i),
    .f2i_i     (f2i_i),
    .rmode_i   (rmode_i),
    .req_o     (req)
  );

  // stage 1
  fpu_align i_fpu_align (
    .clk        (clk),
    .rst        (rst),
    .adv_i      (adv_i),
    .flush_i    (flush_i),
    .req_i      (req),
    .s1_o       (s1),
    .s1_valid_o (s1_valid)
  );

  // stage 2
  fpu_round i_fpu_round (
    .clk        (clk),
    .rst        (rst),
    .adv_i      (adv_i),
    .flush_i    (flush_i),
    .rmode_i    (rmode_i),
    .s1_i       (s1),
    .s1_valid_i (s1_valid),
    .result_o   (result_o),
    .valid_o    (valid_o),
    .fpcsr_o    (fpcsr_o)
  );

endmodule

`default_nettype wire

// File: tb/fpu_rnd_model.svh
`ifndef FPU_RND_MODEL_SVH
`define FPU_RND_MODEL_SVH

////////////////////
// align stage
////////////////////

// expected stage-1 contents for one set of producer inputs
function automatic fpu_rnd_pkg::stage1_t align_model(
  input logic                  add_v,
  input logic                  mul_v,
  input logic                  f2i_v,
  input fpu_rnd_pkg::add_src_t a,
  input fpu_rnd_pkg::mul_src_t m,
  input fpu_rnd_pkg::f2i_src_t f,
  input fpu_rnd_pkg::rmode_e   rm
);
  fpu_rnd_pkg::stage1_t o;
  logic [34:0] fr;     // working fraction before the shift
  logic [4:0]  rsh;
  logic [4:0]  lsh;
  logic        carry;
  logic [9:0]  e_r;
  logic [9:0]  e_l;
  logic [9:0]  e_0;
  logic [95:0] wide;   // fraction on top, shifted-out bits land below
  o     = '0;
  fr    = '0;
  rsh   = '0;
  lsh   = '0;
  carry = 1'b0;
  e_r   = '0;
  e_l   = '0;
  e_0   = '0;
  if (add_v) begin
    // exact zero difference is -0 only toward -inf
    o.sign  = a.sub_zero ? (rm == fpu_rnd_pkg::RM_TO_INFM) : a.sign;
    fr      = {7'd0, a.fract};
    lsh     = a.shl;
    carry   = a.fract[27];
    e_l     = a.exp_shl;
    e_0     = a.exp_sh0;
    o.flags = a.flags;
  end else if (mul_v) begin
    o.sign  = m.sign;
    fr      = {7'd0, m.fract};
    rsh     = m.shr;
    lsh     = {4'd0, m.shl};
    carry   = m.fract[27];
    e_r     = m.exp_shr;
    e_l     = m.exp_shl;
    e_0     = m.exp_sh0;
    o.flags = m.flags;
  end else if (f2i_v) begin
    o.sign           = f.sign;
    fr               = {8'd0, f.int24, 3'd0}; // integer lsb lands on fract32 bit 0
    rsh              = f.shr;
    lsh              = {1'b0, f.shl};
    o.flags.snan     = f.snan;
    o.flags.nan_sign = f.sign;
    o.is_f2i         = 1'b1;
    o.f2i_ovf        = f.ovf;
  end
  wide = {fr, 61'd0};
  if (rsh != 5'd0) begin
    wide  = wide >> rsh;
    o.exp = e_r;
  end else if (carry) begin
    wide  = wide >> 1;           // 1x.xxx back to 1.xxx
    o.exp = (lsh == 5'd0) ? e_0 + 10'd1 : e_l;
  end else begin
    wide  = wide << lsh;
    o.exp = (lsh == 5'd0) ? e_0 : e_l;
  end
  o.fract32 = wide[95:64];
  o.rs      = {wide[63], |wide[62:0]}; // round, everything below it
  return o;
endfunction

////////////////////
// round stage
////////////////////

// expected result word and flags from stage-1 contents and the current mode
function automatic void round_model(
  input  fpu_rnd_pkg::stage1_t s,
  input  fpu_rnd_pkg::rmode_e  rm,
  output logic [31:0]          res,
  output fpu_rnd_pkg::fpcsr_t  csr
);
  logic        rb;
  logic        sb;
  logic        lost;
  logic        up;
  logic [24:0] sum;
  logic [23:0] mant;
  logic [9:0]  e;
  logic        over;
  rb   = s.rs[1];
  sb   = s.rs[0];
  lost = rb | sb;
  case (rm)
    fpu_rnd_pkg::RM_NEAREST: up = rb & (sb | s.fract32[0]); // ties to even
    fpu_rnd_pkg::RM_TO_INFP: up = ~s.sign & lost;
    fpu_rnd_pkg::RM_TO_INFM: up = s.sign & lost;
    default:                 up = 1'b0;
  endcase
  sum = s.fract32[24:0] + 25'(up);
  if (sum[24]) begin
    mant = sum[24:1];   // carry out, one more exponent step
    e    = s.exp + 10'd1;
  end else begin
    mant = sum[23:0];
    e    = s.exp;
  end
  res     = '0;
  csr     = '0;
  csr.snf = s.flags.inv | (s.is_f2i & s.flags.snan);
  csr.qnf = s.flags.qnan;
  csr.ivf = s.flags.inv | s.flags.snan;
  if (s.is_f2i) begin
    over = s.f2i_ovf | (~s.sign & s.fract32[31]);
    if (over) begin
      res = s.sign ? 32'h8000_0000 : 32'h7fff_ffff;
    end else begin
      res = s.sign ? 32'd0 - s.fract32 : s.fract32;
    end
    csr.ivf = csr.ivf | over;
    csr.ixf = lost;
    csr.zf  = ~over & (res == 32'd0);
  end else if (s.flags.snan | s.flags.qnan) begin
    res = {s.flags.nan_sign, 31'h7fc0_0000};
  end else if (s.flags.inv) begin
    res = {s.sign, 31'h7fbf_ffff};
  end else if (s.flags.inf | (e > 10'd254)) begin
    res     = {s.sign, 31'h7f80_0000};
    csr.inf = 1'b1;
    csr.ovf = ~s.flags.inf;
    csr.ixf = lost | ~s.flags.inf;
  end else if (!mant[23]) begin
    res     = {s.sign, 8'd0, mant[22:0]}; // denormal or zero
    csr.unf = lost;
    csr.ixf = lost;
    csr.zf  = (mant == 24'd0);
  end else begin
    res     = {s.sign, e[7:0], mant[22:0]};
    csr.ixf = lost;
  end
endfunction

`endif

// File: tb/fpu_rnd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_rnd_tb;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 16;
  localparam int NUM_CYCLES  = 3000;
  localparam int WATCHDOG_NS = (RST_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD;

  logic                  clk;
  logic                  rst;
  logic                  adv;
  logic                  flush;
  fpu_rnd_pkg::rmode_e   rmode;
  logic                  add_rdy;
  logic                  mul_rdy;
  logic                  f2i_rdy;
  fpu_rnd_pkg::add_src_t add_src;
  fpu_rnd_pkg::mul_src_t mul_src;
  fpu_rnd_pkg::f2i_src_t f2i_src;
  logic [31:0]           result;
  logic                  valid;
  fpu_rnd_pkg::fpcsr_t   fpcsr;

  integer                seed;
  int                    n_checked;    // valid results compared
  // two-deep scoreboard pipe
  fpu_rnd_pkg::stage1_t  sb_s1;
  logic                  sb_s1_valid;
  logic                  sb_valid;
  logic [31:0]           sb_result;
  fpu_rnd_pkg::fpcsr_t   sb_csr;
  logic                  sb_live;      // set once reset was seen

  `include "fpu_rnd_model.svh"

  fpu_rnd_top i_fpu_rnd_top (
    .clk       (clk),
    .rst       (rst),
    .adv_i     (adv),
    .flush_i   (flush),
    .rmode_i   (rmode),
    .add_rdy_i (add_rdy),
    .add_i     (add_src),
    .mul_rdy_i (mul_rdy),
    .mul_i     (mul_src),
    .f2i_rdy_i (f2i_rdy),
    .f2i_i     (f2i_src),
    .result_o  (result),
    .valid_o   (valid),
    .fpcsr_o   (fpcsr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // random payloads
  ////////////////////

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // mostly normal range with some near and past overflow
  function automatic logic [9:0] pick_exp();
    int unsigned kind;
    kind = pick(16);
    if (kind == 0) return 10'(254 + pick(2));
    if (kind == 1) return 10'(256 + pick(40));
    return 10'(1 + pick(253));
  endfunction

  function automatic fpu_rnd_pkg::nan_flags_t pick_flags();
    fpu_rnd_pkg::nan_flags_t f;
    f          = '0;
    f.nan_sign = 1'(pick(2));
    case (pick(20))
      0: f.inf  = 1'b1;
      1: f.qnan = 1'b1;
      2: f.snan = 1'b1;
      3: f.inv  = 1'b1;
      4: {f.snan, f.qnan} = 2'b11;
      default: f.inf = 1'b0;
    endcase
    return f;
  endfunction

  function automatic fpu_rnd_pkg::add_src_t make_add();
    fpu_rnd_pkg::add_src_t a;
    logic [27:0]           r28;
    int unsigned           sh;
    a         = '0;
    r28       = 28'($random(seed));
    a.sign    = 1'(pick(2));
    a.exp_sh0 = pick_exp();
    a.exp_shl = pick_exp();
    a.flags   = pick_flags();
    case (pick(8))
      0: a.fract = {1'b1, r28[26:0]};                  // carry needs one step right
      1: begin
        sh      = 1 + pick(4);                         // leading one at 26-sh
        a.shl   = 5'(sh);
        a.fract = (r28 >> (sh + 1)) | (28'd1 << (26 - sh));
      end
      2: a.sub_zero = 1'b1;                            // x - x
      3: a.fract = r28 >> (2 + pick(10));              // denormal range
      4: a.fract = {2'b01, 23'h7f_ffff, r28[2:0]};     // rounding may carry out
      default: a.fract = {2'b01, r28[25:0]};
    endcase
    return a;
  endfunction

  function automatic fpu_rnd_pkg::mul_src_t make_mul();
    fpu_rnd_pkg::mul_src_t m;
    logic [27:0]           r28;
    m         = '0;
    r28       = 28'($random(seed));
    m.sign    = 1'(pick(2));
    m.exp_shr = pick_exp();
    m.exp_shl = pick_exp();
    m.exp_sh0 = pick_exp();
    m.flags   = pick_flags();
    case (pick(4))
      0: begin
        m.shr   = 5'(1 + pick(26));
        m.fract = {r28[27], 1'b1, r28[25:0]};
      end
      1: begin
        m.shl   = 1'b1;
        m.fract = {3'b001, r28[24:0]};
      end
      2: m.fract = {2'b01, 23'h7f_ffff, r28[2:0]};
      default: m.fract = {r28[27], 1'b1, r28[25:0]};
    endcase
    return m;
  endfunction

  function automatic fpu_rnd_pkg::f2i_src_t make_f2i();
    fpu_rnd_pkg::f2i_src_t f;
    f       = '0;
    f.sign  = 1'(pick(2));
    f.int24 = 24'($random(seed));
    f.snan  = (pick(32) == 0);
    f.ovf   = (pick(16) == 0);
    if (f.ovf) begin
      f.shl = 4'(pick(16));          // any size as it saturates anyway
    end else if (pick(2) == 0) begin
      f.shr = 5'(1 + pick(24));      // drops fraction bits
    end else begin
      f.shl = 4'(pick(8));           // top bit stays at or below 30
    end
    return f;
  endfunction

  task automatic drive_next();
    int unsigned src;
    src = pick(4);                   // 3 means idle
    add_rdy <= (src == 0);
    mul_rdy <= (src == 1);
    f2i_rdy <= (src == 2);
    add_src <= make_add();
    mul_src <= make_mul();
    f2i_src <= make_f2i();
    rmode   <= fpu_rnd_pkg::rmode_e'(pick(4));
    adv     <= (pick(10) < 8);
    flush   <= (pick(32) == 0);
  endtask

  ////////////////////
  // scoreboard
  ////////////////////

  // one rising edge of the pipe on the inputs the DUT samples
  task automatic model_step();
    logic [31:0]         res;
    fpu_rnd_pkg::fpcsr_t csr;
    round_model(sb_s1, rmode, res, csr); // mode as seen in stage 2
    if (rst || flush) begin
      sb_valid    = 1'b0;
      sb_result   = '0;
      sb_csr      = '0;
      sb_s1_valid = 1'b0;
      sb_live     = sb_live | rst;
    end else if (adv) begin
      sb_valid = sb_s1_valid;
      if (sb_s1_valid) begin
        sb_result = res;                  // bubbles leave result and flags alone
        sb_csr    = csr;
      end
      sb_s1_valid = add_rdy | mul_rdy | f2i_rdy;
    end
    if (adv) begin
      sb_s1 = align_model(add_rdy, mul_rdy, f2i_rdy, add_src, mul_src, f2i_src, rmode);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s: got %h expected %h", $time, name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    if (sb_live) begin
      check_value("valid_o", 32'(valid), 32'(sb_valid));
      check_value("result_o", result, sb_result);
      check_value("fpcsr_o", 32'(fpcsr), 32'(sb_csr));
      if (sb_valid) n_checked++;
    end
  endtask

  ////////////////////
  // main
  ////////////////////

  initial begin
    seed        = 32'h4bf1581c;
    rst         = 1'b1;
    adv         = 1'b1;    // loads stage 1 with zeros during reset
    flush       = 1'b0;
    rmode       = fpu_rnd_pkg::RM_NEAREST;
    add_rdy     = 1'b0;
    mul_rdy     = 1'b0;
    f2i_rdy     = 1'b0;
    add_src     = '0;
    mul_src     = '0;
    f2i_src     = '0;
    n_checked   = 0;
    sb_s1       = '0;
    sb_s1_valid = 1'b0;
    sb_valid    = 1'b0;
    sb_result   = '0;
    sb_csr      = '0;
    sb_live     = 1'b0;
    for (int c = 1; c <= RST_CYCLES + NUM_CYCLES; c++) begin
      @(posedge clk);
      model_step();
      if (c == RST_CYCLES) rst <= 1'b0;
      if (c >= RST_CYCLES) drive_next();
      @(negedge clk);       // outputs settled
      check_outputs();
    end
    if (n_checked > 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("no valid result came out of the pipe");
      $display("SIMULATION FAILED");
      $fatal(1, "no results");
    end
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired and the run hung");
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
src/fpu_rnd_pkg.sv
src/fpu_src_mux.sv
src/fpu_align.sv
src/fpu_round.sv
src/fpu_rnd_top.sv
tb/fpu_rnd_tb.sv

// File: run_sim.sh
#!/bin/sh
# verilator build and run, verdict taken from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f vlog.f --top-module fpu_rnd_tb > build.log 2>&1 ||
  { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vfpu_rnd_tb > sim.log 2>&1
grep -q "SIMULATION FAILED" sim.log && { echo "test failed, see sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "test passed"
exit 0
